// File: hdl/qa_cci_pkg.sv
// ============================================================
// CCI request shim package with request and response structs
// and the sizing constants of the buffer and host memory
// ============================================================
`default_nettype none

package qa_cci_pkg;

    // ============================================================
    // Sizing constants
    // ============================================================

    // Data word and word address widths of the scratchpad
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;
    // Tag carried from request to response
    localparam int TAG_W = 4;
    // Scratchpad depth, one word per address
    localparam int MEM_WORDS = 256;
    // Lockstep buffer depth and the free-slot level that raises almost-full
    localparam int BUF_ENTRIES = 8;
    localparam int BUF_THRESHOLD = 4;

    // ============================================================
    // Tx side, as issued by the AFU
    // ============================================================

    // Header shared by both Tx channels
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [TAG_W-1:0]  tag;
    } cci_hdr_t;

    // Channel 0 only carries reads
    typedef struct packed {
        cci_hdr_t hdr;
        logic     rd_valid;
    } c0_tx_t;

    // Channel 1 carries a write or an interrupt
    typedef struct packed {
        cci_hdr_t          hdr;
        logic [DATA_W-1:0] data;
        logic              wr_valid;
        logic              ir_valid;
    } c1_tx_t;

    // Both channels of one cycle, stored together in the buffer
    typedef struct packed {
        c0_tx_t c0;
        c1_tx_t c1;
    } tx_entry_t;

    // ============================================================
    // Serialized host request stream and Rx responses
    // ============================================================

    typedef enum logic [1:0] {
        REQ_RD,
        REQ_WR,
        REQ_IR
    } host_req_e;

    typedef struct packed {
        logic              valid;
        host_req_e         kind;
        cci_hdr_t          hdr;
        logic [DATA_W-1:0] data;
    } host_req_t;

    typedef struct packed {
        logic              rd_valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } c0_rx_t;

    typedef struct packed {
        logic             wr_valid;
        logic             ir_valid;
        logic [TAG_W-1:0] tag;
    } c1_rx_t;

endpackage

`default_nettype wire

// File: hdl/qa_fifo_lutram.sv
// ============================================================
// Distributed-RAM FIFO for any payload type, with an
// almost-full flag driven by the number of free slots
// ============================================================
`default_nettype none

module qa_fifo_lutram #(
    parameter type T_DATA = logic,
    parameter int N_ENTRIES = 8,
    parameter int THRESHOLD = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,

    input  T_DATA     enq_data,
    input  wire logic enq_en,
    output logic      not_full,
    output logic      almost_full,

    output T_DATA     first,
    input  wire logic deq_en,
    output logic      not_empty
);

    localparam int PTR_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_W = $clog2(N_ENTRIES + 1);

    // Storage is meant to map onto LUT RAM, so it has no reset
    T_DATA ram [N_ENTRIES];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_enq;
    logic do_deq;

    // A push into a full FIFO and a pop from an empty one are ignored
    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    assign not_full  = (count != CNT_W'(N_ENTRIES));
    assign not_empty = (count != '0);

    // Raised while the free slots are at or below the threshold
    assign almost_full = ((CNT_W'(N_ENTRIES) - count) <= CNT_W'(THRESHOLD));

    // Head is read asynchronously so it is visible the cycle after the write
    assign first = ram[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_enq) begin
            ram[wr_ptr] <= enq_data;
        end
    end

    // ============================================================
    // Pointers and occupancy
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Explicit wrap keeps the depth free of a power-of-two limit
            if (do_enq) begin
                wr_ptr <= (wr_ptr == PTR_W'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leave the occupancy unchanged
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/qa_shim_buffer_lockstep.sv
// ============================================================
// Lockstep Tx buffer holding both AFU channels in one entry,
// drained by an explicit dequeue from the consumer
// ============================================================
`default_nettype none

module qa_shim_buffer_lockstep (
    input  wire logic             clk,
    input  wire logic             rst_n,

    // Raw requests from the AFU
    input  qa_cci_pkg::c0_tx_t    afu_c0_tx,
    input  qa_cci_pkg::c1_tx_t    afu_c1_tx,
    output logic                  tx_alm_full,

    // Buffered head toward the serializer
    output qa_cci_pkg::tx_entry_t head,
    output logic                  head_valid,
    input  wire logic             deq,

    // Host memory has finished its clear sweep
    input  wire logic             sweep_done
);

    import qa_cci_pkg::*;

    tx_entry_t enq_entry;
    tx_entry_t fifo_first;
    logic      c0_any;
    logic      c1_any;
    logic      enq_en;
    logic      fifo_not_full;
    logic      fifo_alm_full;
    logic      fifo_not_empty;

    // ============================================================
    // Enqueue side
    // ============================================================

    // A cycle carries a request when any of its valid bits is set
    assign c0_any = afu_c0_tx.rd_valid;
    assign c1_any = afu_c1_tx.wr_valid || afu_c1_tx.ir_valid;

    // Requests presented against a full FIFO are dropped here
    assign enq_en = (c0_any || c1_any) && fifo_not_full;

    // Both channels share one entry so reads and writes keep their order
    assign enq_entry = '{c0: afu_c0_tx, c1: afu_c1_tx};

    qa_fifo_lutram #(
        .T_DATA   (tx_entry_t),
        .N_ENTRIES(BUF_ENTRIES),
        .THRESHOLD(BUF_THRESHOLD)
    ) u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .enq_data   (enq_entry),
        .enq_en     (enq_en),
        .not_full   (fifo_not_full),
        .almost_full(fifo_alm_full),
        .first      (fifo_first),
        .deq_en     (deq),
        .not_empty  (fifo_not_empty)
    );

    // The AFU is also held off while host memory is still being cleared
    assign tx_alm_full = fifo_alm_full || !sweep_done;

    // ============================================================
    // Dequeue side
    // ============================================================

    assign head_valid = fifo_not_empty;

    // Valid bits of the head are only meaningful while the FIFO holds data
    always_comb begin
        head             = fifo_first;
        head.c0.rd_valid = fifo_first.c0.rd_valid && fifo_not_empty;
        head.c1.wr_valid = fifo_first.c1.wr_valid && fifo_not_empty;
        head.c1.ir_valid = fifo_first.c1.ir_valid && fifo_not_empty;
    end

endmodule

`default_nettype wire

// File: hdl/qa_tx_serializer.sv
// ============================================================
// Tx serializer turning each lockstep entry into single host
// requests, channel 1 ahead of channel 0
// ============================================================
`default_nettype none

module qa_tx_serializer (
    input  wire logic             clk,
    input  wire logic             rst_n,

    // Head of the lockstep buffer
    input  qa_cci_pkg::tx_entry_t head,
    input  wire logic             head_valid,
    output logic                  deq,

    // Host request stream
    input  wire logic             host_alm_full,
    output qa_cci_pkg::host_req_t host_req
);

    import qa_cci_pkg::*;

    // Set once the C1 half of a two-channel head has gone out
    logic phase;

    logic c1_pend;
    logic c0_pend;
    logic issue;
    logic issue_c1;

    // Request valid is control state, the rest is payload
    logic                  req_valid_q;
    host_req_e             req_kind_q;
    cci_hdr_t              req_hdr_q;
    logic [DATA_W-1:0]     req_data_q;

    // ============================================================
    // Issue decision
    // ============================================================

    // C1 is still owed unless the phase flag says it already went out
    assign c1_pend = (head.c1.wr_valid || head.c1.ir_valid) && !phase;
    assign c0_pend = head.c0.rd_valid;

    // Nothing moves while the host side signals almost-full
    assign issue = head_valid && !host_alm_full;

    // C1 always goes first when it is pending
    assign issue_c1 = issue && c1_pend;

    // The entry leaves once its last pending half issues
    assign deq = issue && !(c1_pend && c0_pend);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= issue;
            // A stall cycle leaves the phase where it was
            if (issue) begin
                phase <= c1_pend && c0_pend;
            end
        end
    end

    // ============================================================
    // Registered request payload
    // ============================================================

    always_ff @(posedge clk) begin
        if (issue_c1) begin
            req_kind_q <= head.c1.wr_valid ? REQ_WR : REQ_IR;
            req_hdr_q  <= head.c1.hdr;
            req_data_q <= head.c1.data;
        end else if (issue) begin
            // Reads carry no data toward the host
            req_kind_q <= REQ_RD;
            req_hdr_q  <= head.c0.hdr;
            req_data_q <= '0;
        end
    end

    assign host_req = '{
        valid: req_valid_q,
        kind:  req_kind_q,
        hdr:   req_hdr_q,
        data:  req_data_q
    };

endmodule

`default_nettype wire

// File: hdl/qa_mem_responder.sv
// ============================================================
// Loopback host memory that executes serialized requests and
// returns CCI Rx responses one cycle later
// ============================================================
`default_nettype none

module qa_mem_responder (
    input  wire logic             clk,
    input  wire logic             rst_n,

    input  qa_cci_pkg::host_req_t host_req,

    output qa_cci_pkg::c0_rx_t    afu_c0_rx,
    output qa_cci_pkg::c1_rx_t    afu_c1_rx,

    // High once every scratchpad word has been zeroed
    output logic                  sweep_done
);

    import qa_cci_pkg::*;

    // Scratchpad words
    logic [DATA_W-1:0] mem [MEM_WORDS];

    // Clear sweep state
    logic [ADDR_W-1:0] sweep_addr;

    // Single write port shared by the sweep and host writes
    logic              mem_we;
    logic [ADDR_W-1:0] mem_waddr;
    logic [DATA_W-1:0] mem_wdata;

    logic              is_rd;
    logic              is_wr;
    logic              is_ir;

    // Response valids are control, tag and data are payload
    logic              rd_valid_q;
    logic              wr_valid_q;
    logic              ir_valid_q;
    logic [TAG_W-1:0]  rsp_tag_q;
    logic [DATA_W-1:0] rd_data_q;

    assign is_rd = host_req.valid && (host_req.kind == REQ_RD);
    assign is_wr = host_req.valid && (host_req.kind == REQ_WR);
    assign is_ir = host_req.valid && (host_req.kind == REQ_IR);

    // ============================================================
    // Post-reset clear sweep
    // ============================================================

    // One word per cycle, so the sweep lasts MEM_WORDS cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_addr <= '0;
            sweep_done <= 1'b0;
        end else if (!sweep_done) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (sweep_addr == ADDR_W'(MEM_WORDS - 1)) begin
                sweep_done <= 1'b1;
            end
        end
    end

    // The sweep owns the write port until it is done
    always_comb begin
        if (!sweep_done) begin
            mem_we    = 1'b1;
            mem_waddr = sweep_addr;
            mem_wdata = '0;
        end else begin
            mem_we    = is_wr;
            mem_waddr = host_req.hdr.addr;
            mem_wdata = host_req.data;
        end
    end

    // ============================================================
    // Scratchpad and responses
    // ============================================================

    // Write lands at the same edge as its acknowledgement
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        if (host_req.valid) begin
            rsp_tag_q <= host_req.hdr.tag;
        end
        if (is_rd) begin
            rd_data_q <= mem[host_req.hdr.addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
            ir_valid_q <= 1'b0;
        end else begin
            // Every response is a single-cycle pulse
            rd_valid_q <= is_rd;
            wr_valid_q <= is_wr;
            ir_valid_q <= is_ir;
        end
    end

    assign afu_c0_rx = '{rd_valid: rd_valid_q, tag: rsp_tag_q, data: rd_data_q};
    assign afu_c1_rx = '{wr_valid: wr_valid_q, ir_valid: ir_valid_q, tag: rsp_tag_q};

endmodule

`default_nettype wire

// File: hdl/qa_shim_top.sv
// ============================================================
// CCI request shim top with lockstep buffer, serializer and
// loopback host memory
// ============================================================
`default_nettype none

module qa_shim_top (
    input  wire logic          clk,
    input  wire logic          rst_n,

    // AFU Tx requests and their flow control
    input  qa_cci_pkg::c0_tx_t afu_c0_tx,
    input  qa_cci_pkg::c1_tx_t afu_c1_tx,
    output logic               tx_alm_full,

    // Host side stall
    input  wire logic          host_alm_full,

    // AFU Rx responses, unbuffered
    output qa_cci_pkg::c0_rx_t afu_c0_rx,
    output qa_cci_pkg::c1_rx_t afu_c1_rx
);

    import qa_cci_pkg::*;

    // Buffer to serializer
    tx_entry_t head;
    logic      head_valid;
    logic      deq;

    // Serializer to responder
    host_req_t host_req;

    // Responder back to the buffer hold
    logic      sweep_done;

    qa_shim_buffer_lockstep u_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .afu_c0_tx  (afu_c0_tx),
        .afu_c1_tx  (afu_c1_tx),
        .tx_alm_full(tx_alm_full),
        .head       (head),
        .head_valid (head_valid),
        .deq        (deq),
        .sweep_done (sweep_done)
    );

    qa_tx_serializer u_ser (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .head_valid   (head_valid),
        .deq          (deq),
        .host_alm_full(host_alm_full),
        .host_req     (host_req)
    );

    qa_mem_responder u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_req  (host_req),
        .afu_c0_rx (afu_c0_rx),
        .afu_c1_rx (afu_c1_rx),
        .sweep_done(sweep_done)
    );

endmodule

`default_nettype wire

// File: tb/qa_shim_tb.sv
// ============================================================
// Self-checking testbench for the CCI request shim with an
// AFU driver, a reference memory and ordered response checks
// ============================================================
`default_nettype none

module qa_shim_tb;

    import qa_cci_pkg::*;

    // ============================================================
    // Test sizing and cycle budget
    // ============================================================

    localparam int N_POOL      = 8;
    localparam int N_WR        = 12;
    localparam int N_LOCK      = 4;
    localparam int N_IRQ       = 3;
    localparam int N_MIX       = 60;
    localparam int HOLD_CYCLES = 8;
    // Every host request gets 8 cycles, which covers the periodic host stall
    localparam int MAX_CYCLES  = 2 + MEM_WORDS + HOLD_CYCLES + 60
        + 8 * (N_POOL + 2 * N_WR + 2 * N_LOCK + 3 * N_IRQ + 8 + 2 * N_MIX);

    // One expected Rx response, data is zero for C1 acknowledgements
    typedef struct packed {
        host_req_e         kind;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } rsp_t;

    logic   clk = 1'b0;
    logic   rst_n;
    c0_tx_t afu_c0_tx;
    c1_tx_t afu_c1_tx;
    logic   tx_alm_full;
    logic   host_alm_full;
    c0_rx_t afu_c0_rx;
    c1_rx_t afu_c1_rx;

    // Host stall sources: a solid hold and a periodic pattern
    logic hold_host;
    logic stall_mode;
    logic stall_phase = 1'b0;
    int   cycle_cnt = 0;

    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [ADDR_W-1:0] addr_pool [N_POOL];
    logic [ADDR_W-1:0] wr_addrs [N_WR];
    rsp_t              exp_q [$];
    rsp_t              got_rsp;
    rsp_t              want_rsp;
    logic [31:0]       lcg_state = 32'd44876;
    logic [TAG_W-1:0]  next_tag;
    string             test_name;
    int                errors;
    int                test_errors_at_start;
    int                n_checks;
    int                tests_run;
    int                tests_failed;

    assign host_alm_full = hold_host || (stall_mode && stall_phase);

    qa_shim_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .afu_c0_tx    (afu_c0_tx),
        .afu_c1_tx    (afu_c1_tx),
        .tx_alm_full  (tx_alm_full),
        .host_alm_full(host_alm_full),
        .afu_c0_rx    (afu_c0_rx),
        .afu_c1_rx    (afu_c1_rx)
    );

    always #5 clk = ~clk;

    // Cycle limit and the host stall pattern, two stall cycles in every five
    always @(negedge clk) begin
        cycle_cnt   = cycle_cnt + 1;
        stall_phase = (cycle_cnt % 5) < 2;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("ERROR: run exceeded %0d cycles, responses stopped arriving", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // ============================================================
    // Response checker
    // ============================================================

    // Rx pulses last one full cycle, so the falling edge sees each exactly once
    always @(negedge clk) begin
        if (rst_n && (afu_c0_rx.rd_valid || afu_c1_rx.wr_valid || afu_c1_rx.ir_valid)) begin
            n_checks = n_checks + 1;
            assert ($countones({afu_c0_rx.rd_valid, afu_c1_rx.wr_valid,
                                afu_c1_rx.ir_valid}) == 1) else begin
                $display("ERROR: %s: more than one Rx valid in the same cycle", test_name);
                errors = errors + 1;
            end
            assert (exp_q.size() > 0) else begin
                $display("ERROR: %s: Rx response with no request outstanding", test_name);
                errors = errors + 1;
            end
            if (exp_q.size() > 0) begin
                want_rsp = exp_q.pop_front();
                got_rsp.kind = afu_c0_rx.rd_valid ? REQ_RD
                             : (afu_c1_rx.wr_valid ? REQ_WR : REQ_IR);
                got_rsp.tag  = afu_c0_rx.rd_valid ? afu_c0_rx.tag : afu_c1_rx.tag;
                got_rsp.data = afu_c0_rx.rd_valid ? afu_c0_rx.data : '0;
                assert (got_rsp === want_rsp) else begin
                    $display("CHECK FAILED: %s: expected kind %0d tag %h data %h, actual kind %0d tag %h data %h",
                             test_name, want_rsp.kind, want_rsp.tag, want_rsp.data,
                             got_rsp.kind, got_rsp.tag, got_rsp.data);
                    errors = errors + 1;
                end
            end
        end
    end

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic expect_value(input string what, input int want, input int got);
        assert (want == got) else begin
            $display("CHECK FAILED: %s: %s expected %0d actual %0d", test_name, what, want, got);
            errors = errors + 1;
        end
    endtask

    task automatic start_test(input string name);
        test_name            = name;
        test_errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run = tests_run + 1;
        if (errors == test_errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d error(s)", test_name, errors - test_errors_at_start);
        end
    endtask

    // Presents one AFU cycle and queues the responses in program order, C1 first
    task automatic issue_cycle(input logic do_rd, input logic [ADDR_W-1:0] rd_addr,
                               input logic do_c1, input host_req_e c1_kind,
                               input logic [ADDR_W-1:0] c1_addr,
                               input logic [DATA_W-1:0] c1_data);
        rsp_t e;
        while (tx_alm_full) begin
            @(negedge clk);
        end
        afu_c0_tx = '0;
        afu_c1_tx = '0;
        if (do_c1) begin
            afu_c1_tx.hdr.addr = c1_addr;
            afu_c1_tx.hdr.tag  = next_tag;
            afu_c1_tx.data     = c1_data;
            afu_c1_tx.wr_valid = (c1_kind == REQ_WR);
            afu_c1_tx.ir_valid = (c1_kind == REQ_IR);
            // An interrupt leaves the memory alone
            if (c1_kind == REQ_WR) begin
                ref_mem[c1_addr] = c1_data;
            end
            e = '{kind: c1_kind, tag: next_tag, data: '0};
            exp_q.push_back(e);
            next_tag = next_tag + 1'b1;
        end
        if (do_rd) begin
            afu_c0_tx.hdr.addr = rd_addr;
            afu_c0_tx.hdr.tag  = next_tag;
            afu_c0_tx.rd_valid = 1'b1;
            e = '{kind: REQ_RD, tag: next_tag, data: ref_mem[rd_addr]};
            exp_q.push_back(e);
            next_tag = next_tag + 1'b1;
        end
        @(negedge clk);
        afu_c0_tx = '0;
        afu_c1_tx = '0;
    endtask

    // Waits until every queued response came back, then a little longer for strays
    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        int               hold;
        int               idx;
        logic [31:0]      r;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        rst_n      = 1'b0;
        afu_c0_tx  = '0;
        afu_c1_tx  = '0;
        hold_host  = 1'b0;
        stall_mode = 1'b0;
        next_tag   = '0;
        errors     = 0;
        n_checks   = 0;
        tests_run  = 0;
        tests_failed = 0;
        test_name  = "reset_sweep";
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < N_POOL; i++) begin
            r = next_rand();
            addr_pool[i] = r[23:16];
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Sweep holds the AFU off for exactly one cycle per memory word
        start_test("reset_sweep");
        expect_value("tx_alm_full after reset", 1, tx_alm_full);
        hold = 0;
        while (tx_alm_full) begin
            assert (!afu_c0_rx.rd_valid && !afu_c1_rx.wr_valid && !afu_c1_rx.ir_valid) else begin
                $display("ERROR: %s: Rx valid seen before any request", test_name);
                errors = errors + 1;
            end
            hold = hold + 1;
            @(negedge clk);
        end
        expect_value("tx_alm_full hold cycles", MEM_WORDS, hold);
        for (int i = 0; i < N_POOL; i++) begin
            issue_cycle(1'b1, addr_pool[i], 1'b0, REQ_WR, '0, '0);
        end
        wait_drain();
        end_test();

        start_test("write_then_read");
        for (int i = 0; i < N_WR; i++) begin
            r = next_rand();
            wr_addrs[i] = addr_pool[r[18:16]];
            issue_cycle(1'b0, '0, 1'b1, REQ_WR, wr_addrs[i], next_rand());
        end
        for (int i = 0; i < N_WR; i++) begin
            issue_cycle(1'b1, wr_addrs[i], 1'b0, REQ_WR, '0, '0);
        end
        wait_drain();
        end_test();

        // Write and read of one address in the same cycle, the read sees new data
        start_test("lockstep_order");
        for (int i = 0; i < N_LOCK; i++) begin
            a = addr_pool[i];
            issue_cycle(1'b1, a, 1'b1, REQ_WR, a, next_rand());
        end
        wait_drain();
        end_test();

        start_test("interrupt");
        for (int i = 0; i < N_IRQ; i++) begin
            a = addr_pool[N_POOL - 1 - i];
            d = next_rand();
            issue_cycle(1'b0, '0, 1'b1, REQ_WR, a, d);
            issue_cycle(1'b0, '0, 1'b1, REQ_IR, a, next_rand());
            issue_cycle(1'b1, a, 1'b0, REQ_WR, '0, '0);
        end
        wait_drain();
        end_test();

        // Host stall fills the buffer up to the almost-full level
        start_test("back_pressure");
        hold_host = 1'b1;
        for (int i = 0; i < 4; i++) begin
            expect_value("tx_alm_full below threshold", 0, tx_alm_full);
            a = addr_pool[i + 2];
            issue_cycle(1'b1, a, 1'b1, REQ_WR, a, next_rand());
        end
        repeat (HOLD_CYCLES) @(negedge clk);
        expect_value("tx_alm_full with 4 queued", 1, tx_alm_full);
        expect_value("responses outstanding", 8, exp_q.size());
        hold_host = 1'b0;
        wait_drain();
        expect_value("tx_alm_full after release", 0, tx_alm_full);
        end_test();

        // Random traffic under a periodic host stall
        start_test("random_mix");
        stall_mode = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            r   = next_rand();
            idx = r[18:16];
            a   = addr_pool[r[21:19]];
            if (r[22] || !r[23]) begin
                issue_cycle(1'b1, a, r[23], r[24] ? REQ_IR : REQ_WR,
                            addr_pool[idx], next_rand());
            end else begin
                issue_cycle(1'b0, '0, 1'b1, r[24] ? REQ_IR : REQ_WR,
                            addr_pool[idx], next_rand());
            end
        end
        stall_mode = 1'b0;
        wait_drain();
        end_test();

        $display("%0d tests, %0d failed, %0d responses checked, %0d errors",
                 tests_run, tests_failed, n_checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/qa_cci_pkg.sv
hdl/qa_fifo_lutram.sv
hdl/qa_shim_buffer_lockstep.sv
hdl/qa_tx_serializer.sv
hdl/qa_mem_responder.sv
hdl/qa_shim_top.sv
tb/qa_shim_tb.sv

// File: Bender.yml
package:
  name: qa_cci_shim

sources:
  - files:
      - hdl/qa_cci_pkg.sv
      - hdl/qa_fifo_lutram.sv
      - hdl/qa_shim_buffer_lockstep.sv
      - hdl/qa_tx_serializer.sv
      - hdl/qa_mem_responder.sv
      - hdl/qa_shim_top.sv
  - target: test
    files:
      - tb/qa_shim_tb.sv
